// File: rtl/tlb_pkg.sv
package tlb_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int tlb_depth  = 8;
    localparam int tlb_addr_w = 3;

    localparam int tlb_vpage_w = 20;
    localparam int tlb_ppage_w = 20;
    localparam int tlb_perm_w  = 4;

    // fixed flag on top with write and read at the bottom
    localparam int tlb_perm_fixed_bit = 3;

    typedef logic [tlb_addr_w-1:0]  tlb_idx_t;
    typedef logic [tlb_depth-1:0]   tlb_valid_t;
    typedef logic [tlb_vpage_w-1:0] tlb_vpage_t;
    typedef logic [tlb_ppage_w-1:0] tlb_ppage_t;
    typedef logic [tlb_perm_w-1:0]  tlb_perm_t;

    // only read and write take part in the permission check
    localparam tlb_perm_t tlb_perm_rw_mask = 4'b0011;

    // stored word that also serves as the request word
    typedef struct packed {
        tlb_perm_t  perm;
        tlb_ppage_t ppage;
        tlb_vpage_t vpage;
    } tlb_entry_t;

    // ----------------------------------------
    // encodings
    // ----------------------------------------
    // command value 3 is reserved
    typedef enum logic [1:0] {
        CMD_WRITE = 2'd0,
        CMD_READ  = 2'd1,
        CMD_DEL   = 2'd2
    } tlb_cmd_e;

    typedef enum logic [1:0] {
        ERR_NONE    = 2'd0,
        ERR_MISS    = 2'd1,
        ERR_NO_PERM = 2'd2,
        ERR_FULL    = 2'd3
    } tlb_err_e;

    typedef enum logic [1:0] {
        PTR_HOLD = 2'd0,
        PTR_INC  = 2'd1,
        PTR_DEC  = 2'd2,
        PTR_LOAD = 2'd3
    } tlb_ptr_op_e;

    typedef enum logic [3:0] {
        IDLE         = 4'h0,
        WR_START     = 4'h1,
        WR_CHECK     = 4'h2,
        WR_NEW       = 4'h3,
        WR_OCCUP     = 4'h4,
        WR_OVERWRITE = 4'h5,
        RD_START     = 4'h6,
        RD_CHECK     = 4'h7,
        DEL_START    = 4'h8,
        DEL_CHECK    = 4'h9,
        DEL_REMOVE   = 4'hA,
        FINISH       = 4'hF
    } tlb_state_e;

endpackage

// File: rtl/tlb_valid_tracker.sv
`timescale 1ns/1ps

module tlb_valid_tracker (
    input  logic             clk_i,
    input  logic             reset_n_i,
    input  logic             set_i,
    input  logic             clr_i,
    input  tlb_pkg::tlb_idx_t idx_i,
    output logic             empty_o,
    output tlb_pkg::tlb_idx_t first_o,
    output tlb_pkg::tlb_idx_t last_o,
    output logic             bit_o,
    output logic             bit_q_o
);
    import tlb_pkg::*;

    tlb_valid_t valid_q;
    logic       bit_q;

    // one valid flag per slot
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            valid_q <= '0;
            bit_q   <= 1'b0;
        end else begin
            if (set_i) begin
                valid_q[idx_i] <= 1'b1;
            end else if (clr_i) begin
                valid_q[idx_i] <= 1'b0;
            end
            // delayed so it lines up with the synchronous memory read
            bit_q <= valid_q[idx_i];
        end
    end

    // ----------------------------------------
    // lowest and highest valid slot
    // ----------------------------------------
    // both fall back to 0 on an empty buffer
    always_comb begin
        first_o = '0;
        for (int i = tlb_depth - 1; i >= 0; i--) begin
            if (valid_q[i]) begin
                first_o = tlb_idx_t'(i);
            end
        end
    end

    always_comb begin
        last_o = '0;
        for (int i = 0; i < tlb_depth; i++) begin
            if (valid_q[i]) begin
                last_o = tlb_idx_t'(i);
            end
        end
    end

    assign empty_o = ~|valid_q;
    assign bit_o   = valid_q[idx_i];
    assign bit_q_o = bit_q;

endmodule

// File: rtl/tlb_addr_ptr.sv
`timescale 1ns/1ps

module tlb_addr_ptr (
    input  logic                 clk_i,
    input  logic                 reset_n_i,
    input  tlb_pkg::tlb_ptr_op_e op_i,
    input  tlb_pkg::tlb_idx_t    load_i,
    output tlb_pkg::tlb_idx_t    addr_o
);
    import tlb_pkg::*;

    tlb_idx_t addr_q;
    tlb_idx_t addr_d;

    // increment and decrement wrap around the slot range
    always_comb begin
        case (op_i)
            PTR_INC:  addr_d = addr_q + 1'b1;
            PTR_DEC:  addr_d = addr_q - 1'b1;
            PTR_LOAD: addr_d = load_i;
            default:  addr_d = addr_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr_d;
        end
    end

    assign addr_o = addr_q;

endmodule

// File: rtl/tlb_entry_store.sv
`timescale 1ns/1ps

module tlb_entry_store (
    input  logic                clk_i,
    input  logic                reset_n_i,
    input  logic                mem_en_i,
    input  logic                mem_we_i,
    input  logic                capture_i,
    input  tlb_pkg::tlb_idx_t   addr_i,
    input  tlb_pkg::tlb_entry_t req_i,
    output logic                key_match_o,
    output logic                fixed_o,
    output logic                perm_ok_o,
    output tlb_pkg::tlb_entry_t rdata_o
);
    import tlb_pkg::*;

    tlb_entry_t mem_q [tlb_depth];
    tlb_entry_t rd_q;
    tlb_entry_t rdata_q;

    // ----------------------------------------
    // entry array
    // ----------------------------------------
    // single port with read data one cycle after enable
    always_ff @(posedge clk_i) begin
        if (mem_en_i) begin
            if (mem_we_i) begin
                mem_q[addr_i] <= req_i;
            end
            rd_q <= mem_q[addr_i];
        end
    end

    // ----------------------------------------
    // compare against the request
    // ----------------------------------------
    assign key_match_o = (rd_q.vpage == req_i.vpage);
    assign fixed_o     = rd_q.perm[tlb_perm_fixed_bit];

    // at least one of read or write must be granted
    assign perm_ok_o = |(rd_q.perm & req_i.perm & tlb_perm_rw_mask);

    // returned entry is zero when the read ended without a match
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            rdata_q <= '0;
        end else if (capture_i) begin
            if (key_match_o) begin
                rdata_q <= rd_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: rtl/tlb_ctrl_fsm.sv
`timescale 1ns/1ps

module tlb_ctrl_fsm (
    input  logic                 clk_i,
    input  logic                 reset_n_i,
    input  logic                 en_i,
    input  tlb_pkg::tlb_cmd_e    cmd_i,
    input  logic                 empty_i,
    input  tlb_pkg::tlb_idx_t    first_i,
    input  tlb_pkg::tlb_idx_t    last_i,
    input  logic                 vbit_i,
    input  logic                 vbit_q_i,
    input  logic                 key_match_i,
    input  logic                 fixed_i,
    input  logic                 perm_ok_i,
    output tlb_pkg::tlb_ptr_op_e ptr_op_o,
    output tlb_pkg::tlb_idx_t    ptr_load_o,
    input  tlb_pkg::tlb_idx_t    addr_i,
    output logic                 mem_en_o,
    output logic                 mem_we_o,
    output logic                 set_o,
    output logic                 clr_o,
    output logic                 capture_o,
    output logic                 active_o,
    output logic                 done_o,
    output tlb_pkg::tlb_err_e    error_o
);
    import tlb_pkg::*;

    tlb_state_e state_q;
    tlb_state_e state_d;
    tlb_err_e   err_q;
    tlb_err_e   err_d;

    tlb_idx_t last_inc;
    logic     cmd_ok;
    logic     hit;
    logic     scan_up;
    logic     scan_dn;

    assign last_inc = last_i + 1'b1;
    assign cmd_ok   = (cmd_i inside {CMD_WRITE, CMD_READ, CMD_DEL});

    // word read last cycle was valid and carries the requested page
    assign hit = vbit_q_i && key_match_i;

    // the pointer already runs one slot ahead of the word being checked
    assign scan_up = (addr_i > first_i) && (addr_i <= last_i);
    assign scan_dn = (addr_i >= first_i) && (addr_i < last_i);

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_q <= IDLE;
            err_q   <= ERR_NONE;
        end else begin
            state_q <= state_d;
            err_q   <= err_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        err_d      = err_q;
        ptr_op_o   = PTR_HOLD;
        ptr_load_o = first_i;
        mem_en_o   = 1'b0;
        mem_we_o   = 1'b0;
        set_o      = 1'b0;
        clr_o      = 1'b0;
        capture_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (en_i && cmd_ok) begin
                    err_d    = ERR_NONE;
                    ptr_op_o = PTR_LOAD;
                    if (cmd_i == CMD_WRITE) begin
                        // an empty buffer takes the write at slot 0
                        state_d = empty_i ? WR_OVERWRITE : WR_START;
                    end else begin
                        ptr_load_o = last_i;
                        state_d    = (cmd_i == CMD_READ) ? RD_START : DEL_START;
                    end
                end
            end

            // ----------------------------------------
            // write
            // ----------------------------------------
            WR_START: begin
                mem_en_o = 1'b1;
                ptr_op_o = PTR_INC;
                state_d  = WR_CHECK;
            end

            // look for an entry with the same page
            WR_CHECK: begin
                mem_en_o = vbit_i;
                if (hit) begin
                    ptr_op_o = PTR_DEC;
                    state_d  = WR_OVERWRITE;
                end else if (scan_up) begin
                    ptr_op_o = PTR_INC;
                end else begin
                    ptr_op_o   = PTR_LOAD;
                    ptr_load_o = last_inc;
                    state_d    = WR_NEW;
                end
            end

            // slot after the last valid one is most likely free
            WR_NEW: begin
                mem_en_o = 1'b1;
                if (!vbit_i) begin
                    mem_we_o = 1'b1;
                    set_o    = 1'b1;
                    state_d  = FINISH;
                end else begin
                    ptr_op_o = PTR_INC;
                    state_d  = WR_OCCUP;
                end
            end

            // walk past fixed entries until one can be evicted
            WR_OCCUP: begin
                mem_en_o = 1'b1;
                if (!fixed_i) begin
                    ptr_op_o = PTR_DEC;
                    state_d  = WR_OVERWRITE;
                end else if (addr_i == last_inc) begin
                    err_d   = ERR_FULL;
                    state_d = FINISH;
                end else if (vbit_i) begin
                    ptr_op_o = PTR_INC;
                end else begin
                    state_d = WR_OVERWRITE;
                end
            end

            WR_OVERWRITE: begin
                mem_en_o = 1'b1;
                mem_we_o = 1'b1;
                set_o    = 1'b1;
                state_d  = FINISH;
            end

            // ----------------------------------------
            // read
            // ----------------------------------------
            RD_START: begin
                mem_en_o = 1'b1;
                if (vbit_i) begin
                    ptr_op_o = PTR_DEC;
                    state_d  = RD_CHECK;
                end else begin
                    err_d   = ERR_MISS;
                    state_d = FINISH;
                end
            end

            RD_CHECK: begin
                mem_en_o = vbit_i;
                if (hit) begin
                    capture_o = 1'b1;
                    if (!perm_ok_i) begin
                        err_d = ERR_NO_PERM;
                    end
                    state_d = FINISH;
                end else if (scan_dn) begin
                    ptr_op_o = PTR_DEC;
                end else begin
                    capture_o = 1'b1;
                    err_d     = ERR_MISS;
                    state_d   = FINISH;
                end
            end

            // ----------------------------------------
            // delete
            // ----------------------------------------
            DEL_START: begin
                mem_en_o = 1'b1;
                if (vbit_i) begin
                    ptr_op_o = PTR_DEC;
                    state_d  = DEL_CHECK;
                end else begin
                    err_d   = ERR_MISS;
                    state_d = FINISH;
                end
            end

            DEL_CHECK: begin
                mem_en_o = vbit_i;
                if (hit) begin
                    // step back to the matching slot
                    ptr_op_o = PTR_INC;
                    state_d  = DEL_REMOVE;
                end else if (scan_dn) begin
                    ptr_op_o = PTR_DEC;
                end else begin
                    err_d   = ERR_MISS;
                    state_d = FINISH;
                end
            end

            DEL_REMOVE: begin
                clr_o   = 1'b1;
                state_d = FINISH;
            end

            FINISH: begin
                state_d = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign active_o = (state_q != IDLE);
    assign done_o   = (state_q == FINISH);
    assign error_o  = err_q;

endmodule

// File: rtl/tlb_priv_top.sv
`timescale 1ns/1ps

module tlb_priv_top (
    input  logic                clk_i,
    input  logic                reset_n_i,
    input  logic                tlb_en_i,
    input  tlb_pkg::tlb_cmd_e   tlb_cmd_i,
    input  tlb_pkg::tlb_entry_t tlb_wdata_i,
    output tlb_pkg::tlb_entry_t tlb_rdata_o,
    output logic                tlb_active_o,
    output logic                tlb_done_o,
    output tlb_pkg::tlb_err_e   tlb_error_o
);
    import tlb_pkg::*;

    // pointer
    tlb_ptr_op_e ptr_op;
    tlb_idx_t    ptr_load;
    tlb_idx_t    addr;

    // valid tracking
    logic     set;
    logic     clr;
    logic     empty;
    tlb_idx_t first;
    tlb_idx_t last;
    logic     vbit;
    logic     vbit_q;

    // entry store
    logic mem_en;
    logic mem_we;
    logic capture;
    logic key_match;
    logic fixed;
    logic perm_ok;

    tlb_ctrl_fsm u_fsm (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .en_i        (tlb_en_i),
        .cmd_i       (tlb_cmd_i),
        .empty_i     (empty),
        .first_i     (first),
        .last_i      (last),
        .vbit_i      (vbit),
        .vbit_q_i    (vbit_q),
        .key_match_i (key_match),
        .fixed_i     (fixed),
        .perm_ok_i   (perm_ok),
        .ptr_op_o    (ptr_op),
        .ptr_load_o  (ptr_load),
        .addr_i      (addr),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .set_o       (set),
        .clr_o       (clr),
        .capture_o   (capture),
        .active_o    (tlb_active_o),
        .done_o      (tlb_done_o),
        .error_o     (tlb_error_o)
    );

    tlb_addr_ptr u_ptr (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .op_i      (ptr_op),
        .load_i    (ptr_load),
        .addr_o    (addr)
    );

    tlb_valid_tracker u_valid (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .set_i     (set),
        .clr_i     (clr),
        .idx_i     (addr),
        .empty_o   (empty),
        .first_o   (first),
        .last_o    (last),
        .bit_o     (vbit),
        .bit_q_o   (vbit_q)
    );

    tlb_entry_store u_store (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .mem_en_i    (mem_en),
        .mem_we_i    (mem_we),
        .capture_i   (capture),
        .addr_i      (addr),
        .req_i       (tlb_wdata_i),
        .key_match_o (key_match),
        .fixed_o     (fixed),
        .perm_ok_o   (perm_ok),
        .rdata_o     (tlb_rdata_o)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int reset_cycles = 10
) (
    output logic clk_o,
    output logic reset_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // release reset on a falling edge away from the sampling edge
    initial begin
        reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule

// File: include/tb_tlb_cases.svh
`ifndef TB_TLB_CASES_SVH
`define TB_TLB_CASES_SVH

// one row per command
// vp_id and pp_id index the page pools of the testbench
// exp_pp_id is only looked at for a read that should hit
typedef struct packed {
    logic [12*8-1:0] name;
    tlb_cmd_e        cmd;
    logic [3:0]      vp_id;
    logic [3:0]      pp_id;
    tlb_perm_t       perm;
    tlb_err_e        exp_err;
    logic [3:0]      exp_pp_id;
} case_t;

localparam int num_cases = 30;

// perm 4'b1011 is fixed with read and write and 4'b0011 may be evicted
case_t cases [num_cases] = '{
    '{"rd_empty",    CMD_READ,  4'd0,  4'd0,  4'b0001, ERR_MISS,    4'd0},
    '{"wr_a",        CMD_WRITE, 4'd0,  4'd0,  4'b1011, ERR_NONE,    4'd0},
    '{"rd_a",        CMD_READ,  4'd0,  4'd0,  4'b0001, ERR_NONE,    4'd0},
    '{"wr_a_upd",    CMD_WRITE, 4'd0,  4'd13, 4'b1011, ERR_NONE,    4'd0},
    '{"rd_a_upd",    CMD_READ,  4'd0,  4'd0,  4'b0010, ERR_NONE,    4'd13},
    '{"wr_b",        CMD_WRITE, 4'd1,  4'd1,  4'b0001, ERR_NONE,    4'd0},
    '{"rd_b_noperm", CMD_READ,  4'd1,  4'd0,  4'b0010, ERR_NO_PERM, 4'd0},
    '{"rd_b",        CMD_READ,  4'd1,  4'd0,  4'b0001, ERR_NONE,    4'd1},
    '{"del_b",       CMD_DEL,   4'd1,  4'd0,  4'b0000, ERR_NONE,    4'd0},
    '{"rd_b_gone",   CMD_READ,  4'd1,  4'd0,  4'b0001, ERR_MISS,    4'd0},
    '{"del_absent",  CMD_DEL,   4'd2,  4'd0,  4'b0000, ERR_MISS,    4'd0},
    '{"wr_f1",       CMD_WRITE, 4'd3,  4'd3,  4'b1011, ERR_NONE,    4'd0},
    '{"wr_f2",       CMD_WRITE, 4'd4,  4'd4,  4'b1011, ERR_NONE,    4'd0},
    '{"wr_f3",       CMD_WRITE, 4'd5,  4'd5,  4'b1011, ERR_NONE,    4'd0},
    '{"wr_f4",       CMD_WRITE, 4'd6,  4'd6,  4'b0011, ERR_NONE,    4'd0},
    '{"wr_f5",       CMD_WRITE, 4'd7,  4'd7,  4'b1011, ERR_NONE,    4'd0},
    '{"wr_f6",       CMD_WRITE, 4'd8,  4'd8,  4'b1011, ERR_NONE,    4'd0},
    '{"wr_f7",       CMD_WRITE, 4'd9,  4'd9,  4'b1011, ERR_NONE,    4'd0},
    '{"rd_f4",       CMD_READ,  4'd6,  4'd0,  4'b0001, ERR_NONE,    4'd6},
    '{"rd_a_full",   CMD_READ,  4'd0,  4'd0,  4'b0001, ERR_NONE,    4'd13},
    '{"wr_ninth",    CMD_WRITE, 4'd10, 4'd10, 4'b1011, ERR_NONE,    4'd0},
    '{"rd_evicted",  CMD_READ,  4'd6,  4'd0,  4'b0001, ERR_MISS,    4'd0},
    '{"rd_ninth",    CMD_READ,  4'd10, 4'd0,  4'b0001, ERR_NONE,    4'd10},
    '{"wr_full",     CMD_WRITE, 4'd11, 4'd11, 4'b1011, ERR_FULL,    4'd0},
    '{"rd_full",     CMD_READ,  4'd11, 4'd0,  4'b0001, ERR_MISS,    4'd0},
    '{"del_f2",      CMD_DEL,   4'd4,  4'd0,  4'b0000, ERR_NONE,    4'd0},
    '{"rd_f2_gone",  CMD_READ,  4'd4,  4'd0,  4'b0001, ERR_MISS,    4'd0},
    '{"wr_hole",     CMD_WRITE, 4'd12, 4'd12, 4'b1011, ERR_NONE,    4'd0},
    '{"rd_hole",     CMD_READ,  4'd12, 4'd0,  4'b0001, ERR_NONE,    4'd12},
    '{"rd_f1",       CMD_READ,  4'd3,  4'd0,  4'b0001, ERR_NONE,    4'd3}
};

`endif

// File: verification/tb_tlb_priv.sv
`timescale 1ns/1ps

module tb_tlb_priv;
    import tlb_pkg::*;

    `include "tb_tlb_cases.svh"

    localparam int reset_cycles    = 10;
    localparam int cycles_per_case = 40;
    localparam int cycle_limit     = num_cases * cycles_per_case + reset_cycles;

    logic       clk;
    logic       reset_n;
    logic       tlb_en;
    tlb_cmd_e   tlb_cmd;
    tlb_entry_t tlb_wdata;
    tlb_entry_t tlb_rdata;
    logic       tlb_active;
    logic       tlb_done;
    tlb_err_e   tlb_error;

    // page numbers for the table are filled from $random
    tlb_vpage_t vpage_pool [16];
    tlb_ppage_t ppage_pool [16];

    // perm last written for each vpage id
    tlb_perm_t  perm_written [16];

    integer seed;
    int     cycle_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;

    tb_clk_gen #(.reset_cycles(reset_cycles)) u_clk (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    tlb_priv_top u_dut (
        .clk_i        (clk),
        .reset_n_i    (reset_n),
        .tlb_en_i     (tlb_en),
        .tlb_cmd_i    (tlb_cmd),
        .tlb_wdata_i  (tlb_wdata),
        .tlb_rdata_o  (tlb_rdata),
        .tlb_active_o (tlb_active),
        .tlb_done_o   (tlb_done),
        .tlb_error_o  (tlb_error)
    );

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // strobe one command and wait for done before comparing with the row
    task automatic run_case(input case_t tc);
        tlb_entry_t req;
        int         waited;
        int         errs;
        errs      = 0;
        req.vpage = vpage_pool[tc.vp_id];
        req.ppage = (tc.cmd == CMD_WRITE) ? ppage_pool[tc.pp_id] : '0;
        req.perm  = tc.perm;

        @(negedge clk);
        tlb_en    = 1'b1;
        tlb_cmd   = tc.cmd;
        tlb_wdata = req;
        @(negedge clk);
        tlb_en = 1'b0;
        if (tlb_active !== 1'b1) begin
            $display("%0s: active did not rise after the command was accepted", tc.name);
            errs++;
        end

        waited = 0;
        while (tlb_done !== 1'b1 && waited < cycles_per_case) begin
            @(negedge clk);
            waited++;
        end

        if (tlb_done !== 1'b1) begin
            $display("%0s: no done pulse within %0d cycles", tc.name, cycles_per_case);
            errs++;
        end else begin
            if (tlb_error !== tc.exp_err) begin
                $display("MISMATCH %0s error: expected %0d actual %0d",
                         tc.name, tc.exp_err, tlb_error);
                errs++;
            end
            // a hit returns the last ppage written for that vpage
            if (tc.cmd == CMD_READ && tc.exp_err == ERR_NONE) begin
                if (tlb_rdata.ppage !== ppage_pool[tc.exp_pp_id]) begin
                    $display("MISMATCH %0s ppage: expected %h actual %h",
                             tc.name, ppage_pool[tc.exp_pp_id], tlb_rdata.ppage);
                    errs++;
                end
                if (tlb_rdata.vpage !== req.vpage) begin
                    $display("MISMATCH %0s vpage: expected %h actual %h",
                             tc.name, req.vpage, tlb_rdata.vpage);
                    errs++;
                end
                if (tlb_rdata.perm !== perm_written[tc.vp_id]) begin
                    $display("MISMATCH %0s perm: expected %b actual %b",
                             tc.name, perm_written[tc.vp_id], tlb_rdata.perm);
                    errs++;
                end
            end
            // done lasts one cycle and the FSM is idle right after it
            @(negedge clk);
            if (tlb_done !== 1'b0 || tlb_active !== 1'b0) begin
                $display("%0s: done or active still high one cycle after done", tc.name);
                errs++;
            end
        end

        // a successful write leaves its perm with the page
        if (tc.cmd == CMD_WRITE && tc.exp_err == ERR_NONE) begin
            perm_written[tc.vp_id] = tc.perm;
        end

        if (errs == 0) begin
            $display("test %0s: ok", tc.name);
            pass_count++;
        end else begin
            $display("test %0s: failed with %0d errors", tc.name, errs);
            fail_count++;
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rnd;
        tlb_en    = 1'b0;
        tlb_cmd   = CMD_READ;
        tlb_wdata = '0;
        seed      = 32'h7fca;

        // low id bits keep the pages of one pool distinct
        for (int i = 0; i < 16; i++) begin
            rnd             = $random(seed);
            vpage_pool[i]   = {rnd[15:0], i[3:0]};
            rnd             = $random(seed);
            ppage_pool[i]   = {rnd[15:0], i[3:0]};
            perm_written[i] = '0;
        end

        @(posedge reset_n);
        @(negedge clk);
        if (tlb_active !== 1'b0 || tlb_done !== 1'b0 || tlb_error !== ERR_NONE
                || tlb_rdata !== '0) begin
            $display("outputs are not in their reset state after reset");
            fail_count++;
        end else begin
            $display("test reset_state: ok");
            pass_count++;
        end

        for (int n = 0; n < num_cases; n++) begin
            run_case(cases[n]);
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/tlb_pkg.sv
rtl/tlb_valid_tracker.sv
rtl/tlb_addr_ptr.sv
rtl/tlb_entry_store.sv
rtl/tlb_ctrl_fsm.sv
rtl/tlb_priv_top.sv
verification/tb_clk_gen.sv
verification/tb_tlb_priv.sv

// File: Bender.yml
package:
  name: tlb_priv

sources:
  - rtl/tlb_pkg.sv
  - rtl/tlb_valid_tracker.sv
  - rtl/tlb_addr_ptr.sv
  - rtl/tlb_entry_store.sv
  - rtl/tlb_ctrl_fsm.sv
  - rtl/tlb_priv_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_tlb_priv.sv
